// ==== hdl/riscv_decode_pkg.sv ====
package riscv_decode_pkg;

    localparam int INST_W = 32;

    // instruction field positions
    localparam int OPC_LSB   = 2;
    localparam int OPC_MSB   = 6;
    localparam int EXPT_LSB  = 7;
    localparam int F3_LSB    = 12;
    localparam int EXPT_MSB  = 19;
    localparam int IMM_LSB   = 20;
    localparam int F7_LSB    = 25;

    typedef logic [4:0]  eff_opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [11:0] sys_imm_t;

    // opcode bits 6..2 since bits 1..0 are always 11
    localparam eff_opcode_t OPC_LUI    = 5'b01101;
    localparam eff_opcode_t OPC_AUIPC  = 5'b00101;
    localparam eff_opcode_t OPC_JAL    = 5'b11011;
    localparam eff_opcode_t OPC_JALR   = 5'b11001;
    localparam eff_opcode_t OPC_BRANCH = 5'b11000;
    localparam eff_opcode_t OPC_LOAD   = 5'b00000;
    localparam eff_opcode_t OPC_STORE  = 5'b01000;
    localparam eff_opcode_t OPC_ALI    = 5'b00100;
    localparam eff_opcode_t OPC_ALIW   = 5'b00110;
    localparam eff_opcode_t OPC_AL     = 5'b01100;
    localparam eff_opcode_t OPC_ALW    = 5'b01110;
    localparam eff_opcode_t OPC_SYSTEM = 5'b11100;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    localparam sys_imm_t SYS_ECALL  = 12'h000;
    localparam sys_imm_t SYS_EBREAK = 12'h001;
    localparam sys_imm_t SYS_MRET   = 12'h302;

    typedef logic [2:0] gen_type_t;
    typedef logic [2:0] alu_op_t;
    typedef logic [2:0] comp_type_t;
    typedef logic [2:0] shift_type_t;
    typedef logic [2:0] store_type_t;
    typedef logic [2:0] load_type_t;
    typedef logic [2:0] csr_ctrl_t;

    // immediate generator formats
    localparam gen_type_t GEN_CSR    = 3'd1;
    localparam gen_type_t GEN_SHIFT  = 3'd2;
    localparam gen_type_t GEN_STORE  = 3'd3;
    localparam gen_type_t GEN_UPPER  = 3'd4;
    localparam gen_type_t GEN_JAL    = 3'd5;
    localparam gen_type_t GEN_ITYPE  = 3'd6;
    localparam gen_type_t GEN_BRANCH = 3'd7;

    localparam alu_op_t ALU_ADD = 3'd3;
    localparam alu_op_t ALU_SUB = 3'd4;
    localparam alu_op_t ALU_XOR = 3'd5;
    localparam alu_op_t ALU_OR  = 3'd6;
    localparam alu_op_t ALU_AND = 3'd7;

    localparam comp_type_t CMP_EQ  = 3'd2;
    localparam comp_type_t CMP_NE  = 3'd3;
    localparam comp_type_t CMP_LT  = 3'd4;
    localparam comp_type_t CMP_LTU = 3'd5;
    localparam comp_type_t CMP_GE  = 3'd6;
    localparam comp_type_t CMP_GEU = 3'd7;

    localparam shift_type_t SH_SLL  = 3'd1;
    localparam shift_type_t SH_SLLW = 3'd3;
    localparam shift_type_t SH_SRA  = 3'd4;
    localparam shift_type_t SH_SRL  = 3'd5;
    localparam shift_type_t SH_SRAW = 3'd6;
    localparam shift_type_t SH_SRLW = 3'd7;

    localparam store_type_t ST_B = 3'd4;
    localparam store_type_t ST_H = 3'd5;
    localparam store_type_t ST_W = 3'd6;
    localparam store_type_t ST_D = 3'd7;

    localparam load_type_t LD_B  = 3'd1;
    localparam load_type_t LD_H  = 3'd2;
    localparam load_type_t LD_W  = 3'd3;
    localparam load_type_t LD_D  = 3'd4;
    localparam load_type_t LD_BU = 3'd5;
    localparam load_type_t LD_HU = 3'd6;
    localparam load_type_t LD_WU = 3'd7;

    localparam csr_ctrl_t CSR_CTRL_NONE = 3'd4;

endpackage

// ==== hdl/inst_class_if.sv ====
`timescale 1ns/1ps

interface inst_class_if;
    import riscv_decode_pkg::*;

    funct3_t  funct3;
    funct7_t  funct7;
    sys_imm_t sys_imm;

    // one flag per opcode class
    logic lui, auipc, jal, jalr, branch, load, store;
    logic ali, aliw, al, alw, system;

    // group flags derived from the classes
    logic shift, word, al_imm, al_reg, expt;

    modport classify (
        output funct3, funct7, sys_imm,
        output lui, auipc, jal, jalr, branch, load, store,
        output ali, aliw, al, alw, system,
        output shift, word, al_imm, al_reg, expt
    );

    modport decode (
        input funct3, funct7, sys_imm,
        input lui, auipc, jal, jalr, branch, load, store,
        input ali, aliw, al, alw, system,
        input shift, word, al_imm, al_reg, expt
    );

endinterface

// ==== hdl/inst_classify.sv ====
`timescale 1ns/1ps

module inst_classify (
    input  logic [riscv_decode_pkg::INST_W-1:0] inst_i,
    inst_class_if.classify                      cls
);
    import riscv_decode_pkg::*;

    eff_opcode_t eff_opcode;
    logic        al_any;

    assign eff_opcode  = inst_i[OPC_MSB:OPC_LSB];

    // raw fields for the field decoders
    assign cls.funct3  = inst_i[F3_LSB +: 3];
    assign cls.funct7  = inst_i[F7_LSB +: 7];
    assign cls.sys_imm = inst_i[IMM_LSB +: 12];

    assign cls.lui     = (eff_opcode == OPC_LUI);
    assign cls.auipc   = (eff_opcode == OPC_AUIPC);
    assign cls.jal     = (eff_opcode == OPC_JAL);
    assign cls.jalr    = (eff_opcode == OPC_JALR);
    assign cls.branch  = (eff_opcode == OPC_BRANCH);
    assign cls.load    = (eff_opcode == OPC_LOAD);
    assign cls.store   = (eff_opcode == OPC_STORE);
    assign cls.ali     = (eff_opcode == OPC_ALI);
    assign cls.aliw    = (eff_opcode == OPC_ALIW);
    assign cls.al      = (eff_opcode == OPC_AL);
    assign cls.alw     = (eff_opcode == OPC_ALW);
    assign cls.system  = (eff_opcode == OPC_SYSTEM);

    assign cls.al_imm  = cls.ali | cls.aliw;
    assign cls.al_reg  = cls.al | cls.alw;
    assign cls.word    = cls.aliw | cls.alw;
    assign al_any      = cls.al_imm | cls.al_reg;

    // funct3 of 001 and 101 are the shifts in every ALU class
    assign cls.shift   = al_any & (cls.funct3[1:0] == 2'b01);

    // ecall, ebreak and mret have rs1, funct3 and rd all zero
    assign cls.expt    = cls.system & (inst_i[EXPT_MSB:EXPT_LSB] == '0);

endmodule

// ==== hdl/reg_imm_decode.sv ====
`timescale 1ns/1ps

module reg_imm_decode (
    inst_class_if.decode                 cls,
    output logic                         rs1_en_o,
    output logic                         rs2_en_o,
    output logic                         rd_en_o,
    output logic                         jump_base_pc_o,
    output riscv_decode_pkg::gen_type_t  gen_type_o
);
    import riscv_decode_pkg::*;

    logic csr_reg;
    logic imm_alu;

    // csrrw, csrrs, csrrc take rs1; the immediate forms use the field as data
    assign csr_reg = cls.system & ~cls.funct3[2] & (cls.funct3[1:0] != 2'b00);
    assign imm_alu = cls.al_imm & ~cls.shift;

    assign rs1_en_o = cls.jalr | cls.branch | cls.load | cls.store |
                      cls.al_imm | cls.al_reg | csr_reg;
    assign rs2_en_o = cls.branch | cls.store | cls.al_reg;
    assign rd_en_o  = cls.lui | cls.auipc | cls.jal | cls.jalr | cls.load |
                      cls.al_imm | cls.al_reg | cls.system;

    // only jalr jumps relative to rs1
    assign jump_base_pc_o = cls.jalr;

    always_comb begin
        if (cls.store)
            gen_type_o = GEN_STORE;
        else if (cls.lui | cls.auipc)
            gen_type_o = GEN_UPPER;
        else if (cls.jal)
            gen_type_o = GEN_JAL;
        else if (cls.jalr | cls.load | imm_alu)
            gen_type_o = GEN_ITYPE;
        else if (cls.branch)
            gen_type_o = GEN_BRANCH;
        else if (cls.shift)
            gen_type_o = GEN_SHIFT;
        else if (cls.system)
            gen_type_o = GEN_CSR;
        else
            gen_type_o = '0;
    end

endmodule

// ==== hdl/alu_decode.sv ====
`timescale 1ns/1ps

module alu_decode (
    inst_class_if.decode                   cls,
    output riscv_decode_pkg::alu_op_t      alu_op_o,
    output logic                           alu_src_pc_o,
    output logic                           alu_src_imm_o,
    output logic                           shift_num_src_o,
    output logic                           inst_slt_nu_o,
    output logic                           inst_slt_u_o,
    output riscv_decode_pkg::shift_type_t  shift_type_o,
    output riscv_decode_pkg::comp_type_t   comp_type_o
);
    import riscv_decode_pkg::*;

    logic f7_base;
    logic f7_alt;
    logic sh_base;
    logic sh_alt;
    logic nw_ok;
    logic op_add, op_sub, op_xor, op_or, op_and;
    logic sh_ll, sh_rl, sh_ra;

    assign f7_base = (cls.funct7 == F7_BASE);
    assign f7_alt  = (cls.funct7 == F7_ALT);

    // rv64 slli/srli/srai use funct7 bit 0 as shamt bit 5
    assign sh_base = cls.ali ? (cls.funct7[6:1] == F7_BASE[6:1]) : f7_base;
    assign sh_alt  = cls.ali ? (cls.funct7[6:1] == F7_ALT[6:1]) : f7_alt;

    // slt, xor, or, and exist only in the 64-bit classes
    assign nw_ok   = cls.ali | (cls.al & f7_base);

    assign op_add  = (cls.funct3 == 3'b000) & (cls.al_imm | (cls.al_reg & f7_base));
    assign op_sub  = (cls.funct3 == 3'b000) & cls.al_reg & f7_alt;
    assign op_xor  = (cls.funct3 == 3'b100) & nw_ok;
    assign op_or   = (cls.funct3 == 3'b110) & nw_ok;
    assign op_and  = (cls.funct3 == 3'b111) & nw_ok;

    assign inst_slt_nu_o = (cls.funct3 == 3'b010) & nw_ok;
    assign inst_slt_u_o  = (cls.funct3 == 3'b011) & nw_ok;

    assign sh_ll   = cls.shift & ~cls.funct3[2] & sh_base;
    assign sh_rl   = cls.shift & cls.funct3[2] & sh_base;
    assign sh_ra   = cls.shift & cls.funct3[2] & sh_alt;

    // operand a is rs1 for everything except auipc
    assign alu_src_pc_o    = ~cls.auipc;
    assign alu_src_imm_o   = cls.auipc | cls.load | cls.store | (cls.al_imm & ~cls.shift);
    assign shift_num_src_o = cls.shift & cls.al_imm;

    always_comb begin
        if (cls.auipc | cls.load | cls.store | op_add)
            alu_op_o = ALU_ADD;
        else if (inst_slt_nu_o | inst_slt_u_o | op_sub)
            alu_op_o = ALU_SUB;
        else if (op_xor)
            alu_op_o = ALU_XOR;
        else if (op_or)
            alu_op_o = ALU_OR;
        else if (op_and)
            alu_op_o = ALU_AND;
        else
            alu_op_o = '0;
    end

    always_comb begin
        if (sh_ll)
            shift_type_o = cls.word ? SH_SLLW : SH_SLL;
        else if (sh_rl)
            shift_type_o = cls.word ? SH_SRLW : SH_SRL;
        else if (sh_ra)
            shift_type_o = cls.word ? SH_SRAW : SH_SRA;
        else
            shift_type_o = '0;
    end

    // compare codes keep the core's own funct3 mapping
    always_comb begin
        comp_type_o = '0;
        if (cls.branch) begin
            case (cls.funct3)
                3'b000:  comp_type_o = CMP_EQ;
                3'b001:  comp_type_o = CMP_NE;
                3'b100:  comp_type_o = CMP_LT;
                3'b110:  comp_type_o = CMP_LTU;
                3'b101:  comp_type_o = CMP_GE;
                3'b111:  comp_type_o = CMP_GEU;
                default: comp_type_o = '0;
            endcase
        end
    end

endmodule

// ==== hdl/mem_sys_decode.sv ====
`timescale 1ns/1ps

module mem_sys_decode (
    inst_class_if.decode                   cls,
    output logic                           mem_read_o,
    output logic                           mem_write_o,
    output logic                           csr_src_o,
    output logic                           inst_ecall_o,
    output logic                           inst_ebreak_o,
    output logic                           inst_mret_o,
    output logic                           inst_trap_o,
    output riscv_decode_pkg::load_type_t   load_type_o,
    output riscv_decode_pkg::store_type_t  store_type_o,
    output riscv_decode_pkg::csr_ctrl_t    csr_ctrl_o
);
    import riscv_decode_pkg::*;

    assign mem_read_o  = cls.load;
    assign mem_write_o = cls.store;

    // lb..ld then the unsigned widths up to funct3 6
    always_comb begin
        load_type_o = '0;
        if (cls.load) begin
            case (cls.funct3)
                3'd0:    load_type_o = LD_B;
                3'd1:    load_type_o = LD_H;
                3'd2:    load_type_o = LD_W;
                3'd3:    load_type_o = LD_D;
                3'd4:    load_type_o = LD_BU;
                3'd5:    load_type_o = LD_HU;
                3'd6:    load_type_o = LD_WU;
                default: load_type_o = '0;
            endcase
        end
    end

    always_comb begin
        store_type_o = '0;
        if (cls.store) begin
            case (cls.funct3)
                3'd0:    store_type_o = ST_B;
                3'd1:    store_type_o = ST_H;
                3'd2:    store_type_o = ST_W;
                3'd3:    store_type_o = ST_D;
                default: store_type_o = '0;
            endcase
        end
    end

    // the CSR unit decodes funct3 itself
    assign csr_ctrl_o = cls.system ? cls.funct3 : CSR_CTRL_NONE;
    // set for the immediate forms
    assign csr_src_o  = cls.funct3[2];

    assign inst_ecall_o  = cls.expt & (cls.sys_imm == SYS_ECALL);
    assign inst_ebreak_o = cls.expt & (cls.sys_imm == SYS_EBREAK);
    assign inst_mret_o   = cls.expt & (cls.sys_imm == SYS_MRET);
    assign inst_trap_o   = inst_ecall_o | inst_ebreak_o | inst_mret_o;

endmodule

// ==== hdl/id_control.sv ====
`timescale 1ns/1ps

module id_control (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                inst_valid_i,
    input  logic [riscv_decode_pkg::INST_W-1:0] inst_i,
    output logic                                ctrl_valid_o,
    output logic                                rs1_en_o,
    output logic                                rs2_en_o,
    output logic                                rd_en_o,
    output logic                                jump_base_pc_o,
    output riscv_decode_pkg::gen_type_t         gen_type_o,
    output riscv_decode_pkg::alu_op_t           alu_op_o,
    output logic                                alu_src_pc_o,
    output logic                                alu_src_imm_o,
    output logic                                shift_num_src_o,
    output logic                                inst_slt_nu_o,
    output logic                                inst_slt_u_o,
    output riscv_decode_pkg::shift_type_t       shift_type_o,
    output riscv_decode_pkg::comp_type_t        comp_type_o,
    output logic                                mem_read_o,
    output logic                                mem_write_o,
    output logic                                csr_src_o,
    output riscv_decode_pkg::load_type_t        load_type_o,
    output riscv_decode_pkg::store_type_t       store_type_o,
    output riscv_decode_pkg::csr_ctrl_t         csr_ctrl_o,
    output logic                                inst_ecall_o,
    output logic                                inst_ebreak_o,
    output logic                                inst_mret_o,
    output logic                                inst_trap_o,
    output logic                                inst_jump_o,
    output logic                                inst_branch_o,
    output logic                                inst_lui_o,
    output logic                                inst_auipc_o,
    output logic                                inst_word_o,
    output logic                                inst_shift_o,
    output logic                                inst_arth_lgc_o,
    output logic                                inst_load_o,
    output logic                                inst_csr_o
);
    import riscv_decode_pkg::*;

    // field order matches the output concatenation below
    typedef struct packed {
        logic        rs1_en, rs2_en, rd_en, jump_base_pc;
        gen_type_t   gen_type;
        alu_op_t     alu_op;
        logic        alu_src_pc, alu_src_imm, shift_num_src, slt_nu, slt_u;
        shift_type_t shift_type;
        comp_type_t  comp_type;
        logic        mem_read, mem_write, csr_src;
        load_type_t  load_type;
        store_type_t store_type;
        csr_ctrl_t   csr_ctrl;
        logic        ecall, ebreak, mret, trap;
        logic        jump, branch, lui, auipc, word, shift, arth_lgc, load, csr;
    } ctrl_t;

    ctrl_t ctrl_d;
    ctrl_t ctrl_q;

    inst_class_if cls ();

    inst_classify u_classify (
        .inst_i (inst_i),
        .cls    (cls.classify)
    );

    reg_imm_decode u_reg_imm (
        .cls            (cls.decode),
        .rs1_en_o       (ctrl_d.rs1_en),
        .rs2_en_o       (ctrl_d.rs2_en),
        .rd_en_o        (ctrl_d.rd_en),
        .jump_base_pc_o (ctrl_d.jump_base_pc),
        .gen_type_o     (ctrl_d.gen_type)
    );

    alu_decode u_alu (
        .cls             (cls.decode),
        .alu_op_o        (ctrl_d.alu_op),
        .alu_src_pc_o    (ctrl_d.alu_src_pc),
        .alu_src_imm_o   (ctrl_d.alu_src_imm),
        .shift_num_src_o (ctrl_d.shift_num_src),
        .inst_slt_nu_o   (ctrl_d.slt_nu),
        .inst_slt_u_o    (ctrl_d.slt_u),
        .shift_type_o    (ctrl_d.shift_type),
        .comp_type_o     (ctrl_d.comp_type)
    );

    mem_sys_decode u_mem_sys (
        .cls           (cls.decode),
        .mem_read_o    (ctrl_d.mem_read),
        .mem_write_o   (ctrl_d.mem_write),
        .csr_src_o     (ctrl_d.csr_src),
        .inst_ecall_o  (ctrl_d.ecall),
        .inst_ebreak_o (ctrl_d.ebreak),
        .inst_mret_o   (ctrl_d.mret),
        .inst_trap_o   (ctrl_d.trap),
        .load_type_o   (ctrl_d.load_type),
        .store_type_o  (ctrl_d.store_type),
        .csr_ctrl_o    (ctrl_d.csr_ctrl)
    );

    // summary flags for the EX stage
    assign ctrl_d.jump     = cls.jal | cls.jalr;
    assign ctrl_d.branch   = cls.branch;
    assign ctrl_d.lui      = cls.lui;
    assign ctrl_d.auipc    = cls.auipc;
    assign ctrl_d.word     = cls.word;
    assign ctrl_d.shift    = cls.shift;
    assign ctrl_d.arth_lgc = cls.al_imm | cls.al_reg;
    assign ctrl_d.load     = cls.load;
    assign ctrl_d.csr      = cls.system;

    // controls hold their last decode while no instruction arrives
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_valid_o <= 1'b0;
            ctrl_q       <= '0;
        end else begin
            ctrl_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                ctrl_q <= ctrl_d;
            end
        end
    end

    assign {rs1_en_o, rs2_en_o, rd_en_o, jump_base_pc_o, gen_type_o, alu_op_o,
            alu_src_pc_o, alu_src_imm_o, shift_num_src_o, inst_slt_nu_o, inst_slt_u_o,
            shift_type_o, comp_type_o, mem_read_o, mem_write_o, csr_src_o,
            load_type_o, store_type_o, csr_ctrl_o,
            inst_ecall_o, inst_ebreak_o, inst_mret_o, inst_trap_o,
            inst_jump_o, inst_branch_o, inst_lui_o, inst_auipc_o, inst_word_o,
            inst_shift_o, inst_arth_lgc_o, inst_load_o, inst_csr_o} = ctrl_q;

    // classifier never raises two opcode classes for one instruction
    a_class_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        inst_valid_i |-> $onehot0({cls.lui, cls.auipc, cls.jal, cls.jalr, cls.branch,
                                   cls.load, cls.store, cls.ali, cls.aliw, cls.al,
                                   cls.alw, cls.system}));

    // registered strobes never request a read and a write together
    a_mem_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_read_o && mem_write_o));

    a_valid_after_rst: assert property (@(posedge clk_i)
        rst_i |=> !ctrl_valid_o);

endmodule

// ==== bench/tb_id_control.sv ====
`timescale 1ns/1ps

module tb_id_control;
    import riscv_decode_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int N_GROUP     = 300;
    localparam int N_B2B       = 500;
    localparam int TOTAL_INST  = 5 + 4 * N_GROUP + N_B2B;
    // idle cycles and drains at most double the cycle count
    localparam int WATCHDOG_NS = (TOTAL_INST * 2 + 200) * CLK_PERIOD;

    typedef struct packed {
        logic        rs1_en, rs2_en, rd_en, jump_base_pc;
        gen_type_t   gen_type;
        alu_op_t     alu_op;
        logic        alu_src_pc, alu_src_imm, shift_num_src, slt_nu, slt_u;
        shift_type_t shift_type;
        comp_type_t  comp_type;
        logic        mem_read, mem_write, csr_src;
        load_type_t  load_type;
        store_type_t store_type;
        csr_ctrl_t   csr_ctrl;
        logic        ecall, ebreak, mret, trap;
        logic        jump, branch, lui, auipc, word, shift, arth_lgc, load, csr;
    } ctrl_t;

    logic        clk;
    logic        rst_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        ctrl_valid_o;
    logic        rs1_en_o, rs2_en_o, rd_en_o, jump_base_pc_o;
    logic        alu_src_pc_o, alu_src_imm_o, shift_num_src_o, inst_slt_nu_o, inst_slt_u_o;
    logic        mem_read_o, mem_write_o, csr_src_o;
    logic        inst_ecall_o, inst_ebreak_o, inst_mret_o, inst_trap_o;
    logic        inst_jump_o, inst_branch_o, inst_lui_o, inst_auipc_o, inst_word_o;
    logic        inst_shift_o, inst_arth_lgc_o, inst_load_o, inst_csr_o;
    gen_type_t   gen_type_o;
    alu_op_t     alu_op_o;
    shift_type_t shift_type_o;
    comp_type_t  comp_type_o;
    load_type_t  load_type_o;
    store_type_t store_type_o;
    csr_ctrl_t   csr_ctrl_o;

    integer      seed = 37747;
    ctrl_t       exp_q[$];
    ctrl_t       held = '0;
    logic        exp_valid = 1'b0;
    bit          check_en = 1'b0;
    string       test_name = "reset";
    int          test_checks, test_errors;
    int          total_checks, total_errors, tests_run, tests_failed;

    id_control UUT (.clk_i(clk), .*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one-cycle registered strobe
    always @(posedge clk) begin
        exp_valid <= rst_i ? 1'b0 : inst_valid_i;
    end

    // reference decode from the RV64I encoding rules
    task automatic decode_model(input logic [31:0] inst, output ctrl_t e);
        eff_opcode_t opc;
        funct3_t     f3;
        funct7_t     f7;
        logic        imm, word, sh_base, sh_alt;
        opc = inst[6:2];
        f3  = inst[14:12];
        f7  = inst[31:25];
        e = '0;
        e.csr_ctrl   = CSR_CTRL_NONE;
        e.alu_src_pc = (opc != OPC_AUIPC);
        e.csr_src    = f3[2];
        case (opc)
            OPC_LUI: begin
                e.rd_en    = 1'b1;
                e.gen_type = GEN_UPPER;
                e.lui      = 1'b1;
            end
            OPC_AUIPC: begin
                e.rd_en       = 1'b1;
                e.gen_type    = GEN_UPPER;
                e.alu_op      = ALU_ADD;
                e.alu_src_imm = 1'b1;
                e.auipc       = 1'b1;
            end
            OPC_JAL: begin
                e.rd_en    = 1'b1;
                e.gen_type = GEN_JAL;
                e.jump     = 1'b1;
            end
            OPC_JALR: begin
                e.rs1_en       = 1'b1;
                e.rd_en        = 1'b1;
                e.jump_base_pc = 1'b1;
                e.gen_type     = GEN_ITYPE;
                e.jump         = 1'b1;
            end
            OPC_BRANCH: begin
                e.rs1_en   = 1'b1;
                e.rs2_en   = 1'b1;
                e.gen_type = GEN_BRANCH;
                e.branch   = 1'b1;
                case (f3)
                    3'b000:  e.comp_type = CMP_EQ;
                    3'b001:  e.comp_type = CMP_NE;
                    3'b100:  e.comp_type = CMP_LT;
                    3'b101:  e.comp_type = CMP_GE;
                    3'b110:  e.comp_type = CMP_LTU;
                    3'b111:  e.comp_type = CMP_GEU;
                    default: e.comp_type = '0;
                endcase
            end
            OPC_LOAD: begin
                e.rs1_en      = 1'b1;
                e.rd_en       = 1'b1;
                e.gen_type    = GEN_ITYPE;
                e.alu_op      = ALU_ADD;
                e.alu_src_imm = 1'b1;
                e.mem_read    = 1'b1;
                e.load        = 1'b1;
                // lb lh lw ld lbu lhu lwu in funct3 order
                e.load_type   = (f3 == 3'b111) ? 3'd0 : f3 + 3'd1;
            end
            OPC_STORE: begin
                e.rs1_en      = 1'b1;
                e.rs2_en      = 1'b1;
                e.gen_type    = GEN_STORE;
                e.alu_op      = ALU_ADD;
                e.alu_src_imm = 1'b1;
                e.mem_write   = 1'b1;
                e.store_type  = f3[2] ? 3'd0 : f3 + 3'd4;
            end
            OPC_SYSTEM: begin
                e.rd_en    = 1'b1;
                e.gen_type = GEN_CSR;
                e.csr      = 1'b1;
                e.csr_ctrl = f3;
                e.rs1_en   = !f3[2] && (f3 != 3'b000);
                if (inst[19:7] == 13'd0) begin
                    e.ecall  = (inst[31:20] == SYS_ECALL);
                    e.ebreak = (inst[31:20] == SYS_EBREAK);
                    e.mret   = (inst[31:20] == SYS_MRET);
                    e.trap   = e.ecall | e.ebreak | e.mret;
                end
            end
            OPC_ALI, OPC_ALIW, OPC_AL, OPC_ALW: begin
                imm  = (opc == OPC_ALI) || (opc == OPC_ALIW);
                word = (opc == OPC_ALIW) || (opc == OPC_ALW);
                e.rs1_en   = 1'b1;
                e.rs2_en   = !imm;
                e.rd_en    = 1'b1;
                e.word     = word;
                e.arth_lgc = 1'b1;
                if (f3[1:0] == 2'b01) begin
                    e.shift         = 1'b1;
                    e.gen_type      = GEN_SHIFT;
                    e.shift_num_src = imm;
                    // slli/srli/srai carry shamt bit 5 in funct7 bit 0
                    sh_base = (opc == OPC_ALI) ? (f7[6:1] == 6'b000000) : (f7 == F7_BASE);
                    sh_alt  = (opc == OPC_ALI) ? (f7[6:1] == 6'b010000) : (f7 == F7_ALT);
                    if (!f3[2] && sh_base)
                        e.shift_type = word ? SH_SLLW : SH_SLL;
                    else if (f3[2] && sh_base)
                        e.shift_type = word ? SH_SRLW : SH_SRL;
                    else if (f3[2] && sh_alt)
                        e.shift_type = word ? SH_SRAW : SH_SRA;
                end else begin
                    if (imm) begin
                        e.gen_type    = GEN_ITYPE;
                        e.alu_src_imm = 1'b1;
                    end
                    if (f3 == 3'b000) begin
                        if (imm || f7 == F7_BASE)
                            e.alu_op = ALU_ADD;
                        else if (f7 == F7_ALT)
                            e.alu_op = ALU_SUB;
                    end else if (!word && (imm || f7 == F7_BASE)) begin
                        case (f3)
                            3'b010:  e.slt_nu = 1'b1;
                            3'b011:  e.slt_u = 1'b1;
                            3'b100:  e.alu_op = ALU_XOR;
                            3'b110:  e.alu_op = ALU_OR;
                            default: e.alu_op = ALU_AND;
                        endcase
                        if (e.slt_nu || e.slt_u)
                            e.alu_op = ALU_SUB;
                    end
                end
            end
            default: ;
        endcase
    endtask

    function automatic ctrl_t sample_dut();
        return {rs1_en_o, rs2_en_o, rd_en_o, jump_base_pc_o, gen_type_o, alu_op_o,
                alu_src_pc_o, alu_src_imm_o, shift_num_src_o, inst_slt_nu_o, inst_slt_u_o,
                shift_type_o, comp_type_o, mem_read_o, mem_write_o, csr_src_o,
                load_type_o, store_type_o, csr_ctrl_o,
                inst_ecall_o, inst_ebreak_o, inst_mret_o, inst_trap_o,
                inst_jump_o, inst_branch_o, inst_lui_o, inst_auipc_o, inst_word_o,
                inst_shift_o, inst_arth_lgc_o, inst_load_o, inst_csr_o};
    endfunction

    // kind 0..11 picks a class and 12 or more a random opcode
    task automatic make_inst(input int kind, output logic [31:0] inst);
        logic [31:0] r;
        eff_opcode_t opc;
        r    = $random(seed);
        inst = $random(seed);
        case (kind)
            0:       opc = OPC_LUI;
            1:       opc = OPC_AUIPC;
            2:       opc = OPC_ALI;
            3:       opc = OPC_ALIW;
            4:       opc = OPC_AL;
            5:       opc = OPC_ALW;
            6:       opc = OPC_JAL;
            7:       opc = OPC_JALR;
            8:       opc = OPC_BRANCH;
            9:       opc = OPC_LOAD;
            10:      opc = OPC_STORE;
            11:      opc = OPC_SYSTEM;
            default: opc = r[31:27];
        endcase
        inst[6:0] = {opc, 2'b11};
        // legal funct7 three times in four
        if (r[1:0] != 2'b11)
            inst[31:25] = r[1] ? F7_ALT : F7_BASE;
        // shamt bit 5 is legal only in the 64-bit immediate shifts
        if (opc == OPC_ALI || opc == OPC_ALIW)
            inst[25] = r[2];
        if (opc == OPC_SYSTEM && r[4:3] != 2'b00) begin
            inst[19:7] = '0;
            // now and then one stray bit in rd, funct3 or rs1
            if (r[8:7] == 2'b11)
                inst[7 + int'(r[12:9]) % 13] = 1'b1;
            case (r[6:5])
                2'd0:    inst[31:20] = SYS_ECALL;
                2'd1:    inst[31:20] = SYS_EBREAK;
                2'd2:    inst[31:20] = SYS_MRET;
                default: ;
            endcase
        end
    endtask

    task automatic send_inst(input logic [31:0] inst);
        ctrl_t e;
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        decode_model(inst, e);
        exp_q.push_back(e);
    endtask

    // junk on inst_i must not disturb the held controls
    task automatic send_idle();
        @(posedge clk);
        inst_valid_i <= 1'b0;
        inst_i       <= $random(seed);
    endtask

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        send_idle();
        while (exp_q.size() != 0)
            @(posedge clk);
        send_idle();
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("%-16s %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic run_group(input string name, input int first, input int span,
                             input int count, input bit idles);
        logic [31:0] inst;
        logic [31:0] r;
        start_test(name);
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            if (idles && r[2:0] == 3'b000)
                send_idle();
            make_inst(first + int'(r[15:4]) % span, inst);
            send_inst(inst);
        end
        end_test();
    endtask

    always @(negedge clk) begin
        ctrl_t act;
        if (check_en) begin
            act = sample_dut();
            test_checks++;
            total_checks++;
            assert (ctrl_valid_o === exp_valid) else begin
                $display("** Error [%s] ctrl_valid_o expected %0b actual %0b",
                         test_name, exp_valid, ctrl_valid_o);
                note_error();
            end
            if (ctrl_valid_o === 1'b1) begin
                assert (exp_q.size() != 0) else begin
                    $display("[%s] ctrl_valid_o rose with no instruction outstanding",
                             test_name);
                    note_error();
                end
                if (exp_q.size() != 0)
                    held = exp_q.pop_front();
            end
            assert (act === held) else begin
                $display("** Error [%s] controls expected %h actual %h",
                         test_name, held, act);
                note_error();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all decode results were returned");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] inst;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        repeat (3) @(posedge clk);
        rst_i    <= 1'b0;
        check_en = 1'b1;

        start_test("reset_strobe");
        repeat (3) send_idle();
        make_inst(4, inst);
        send_inst(inst);
        send_idle();
        send_idle();
        make_inst(9, inst);
        send_inst(inst);
        make_inst(11, inst);
        send_inst(inst);
        end_test();

        run_group("alu_shift_upper", 0, 6, N_GROUP, 1'b1);
        run_group("branch_jump", 6, 3, N_GROUP, 1'b1);
        run_group("load_store", 9, 2, N_GROUP, 1'b1);
        run_group("system", 11, 1, N_GROUP, 1'b1);
        run_group("back_to_back", 0, 13, N_B2B, 1'b0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/riscv_decode_pkg.sv
hdl/inst_class_if.sv
hdl/inst_classify.sv
hdl/reg_imm_decode.sv
hdl/alu_decode.sv
hdl/mem_sys_decode.sv
hdl/id_control.sv
bench/tb_id_control.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
{ verilator --binary --timing --assert -j 0 --top-module tb_id_control -f build.f \
    --Mdir obj_dir -o sim_id_control && ./obj_dir/sim_id_control; } > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
